// File: rtl/mz80k_pkg.sv
package mz80k_pkg;

	// core reset stretch
	localparam int reset_cnt_w = 8;
	localparam logic [reset_cnt_w-1:0] reset_hold = 8'd255; // counter saturates here

	// colour widths
	localparam int color_w = 2; // one core channel
	localparam int vga_w = 6;   // one board VGA channel

	// audio
	localparam int dac_w = 3; // modulator input and accumulator width

	// key word from the board controller
	localparam int ps2_key_w = 11;
	localparam int key_toggle_bit = 10;  // flips once per key event
	localparam int key_pressed_bit = 9;  // 1 = make, 0 = break
	localparam int key_ext_bit = 8;      // E0 prefixed code

	// screen modes from the menu, code 3 is treated as colour too
	localparam logic [1:0] mode_gray = 2'd0;
	localparam logic [1:0] mode_green = 2'd1;
	localparam logic [1:0] mode_color = 2'd2;

	// status word bit positions
	localparam int status_menu_reset = 0;
	localparam int status_trig_reset = 5;
	localparam int status_mode_lo = 3; // mode sits in this bit and the one above

	// set 2 scan codes of the shift keys
	localparam logic [7:0] scan_lshift = 8'h12;
	localparam logic [7:0] scan_rshift = 8'h59;

endpackage

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer
	import mz80k_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  logic pll_locked,
	input  logic hold_button,
	input  logic menu_reset,
	input  logic trig_reset,
	output logic core_reset
);

	logic src_active;
	logic src_q;
	logic [reset_cnt_w-1:0] hold_cnt;

	// any one of these keeps the core parked
	assign src_active = !pll_locked || hold_button || menu_reset || trig_reset;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			src_q <= 1'b1;
			hold_cnt <= '0;
			core_reset <= 1'b1;
		end else begin
			src_q <= src_active; // lock and button are not clk_sys signals
			if (src_q)
				hold_cnt <= '0;
			else if (hold_cnt != reset_hold)
				hold_cnt <= hold_cnt + 1'b1; // stops at the hold value
			// a new source asserts reset at once, release waits for the count
			core_reset <= src_active || src_q || (hold_cnt != reset_hold);
		end
	end

endmodule

// File: rtl/key_event_decoder.sv
`timescale 1ns/1ps

module key_event_decoder
	import mz80k_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [ps2_key_w-1:0] ps2_key,
	output logic                 key_strobe,
	output logic [7:0]           key_code,
	output logic                 key_extended,
	output logic                 key_pressed,
	output logic                 shift_held
);

	logic toggle_q;
	logic new_event;
	logic is_shift;

	// controller flips this bit once for every make or break it sends
	assign new_event = ps2_key[key_toggle_bit] != toggle_q;

	// shift keys have no E0 prefix, an extended 12 is part of print screen
	assign is_shift = !ps2_key[key_ext_bit] &&
		((ps2_key[7:0] == scan_lshift) || (ps2_key[7:0] == scan_rshift));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
			key_strobe <= 1'b0;
			shift_held <= 1'b0;
		end else begin
			toggle_q <= ps2_key[key_toggle_bit];
			key_strobe <= new_event; // one cycle per flip
			if (new_event && is_shift)
				shift_held <= ps2_key[key_pressed_bit]; // make sets, break clears
		end
	end

	// fields only change with an event, so they stay valid after the strobe
	always_ff @(posedge clk_sys) begin
		if (new_event) begin
			key_code <= ps2_key[7:0];
			key_extended <= ps2_key[key_ext_bit];
			key_pressed <= ps2_key[key_pressed_bit];
		end
	end

endmodule

// File: rtl/video_palette.sv
`timescale 1ns/1ps

module video_palette
	import mz80k_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic [1:0]         mode,
	input  logic [color_w-1:0] core_r,
	input  logic [color_w-1:0] core_g,
	input  logic [color_w-1:0] core_b,
	input  logic               core_hs,
	input  logic               core_vs,
	output logic [vga_w-1:0]   vga_r,
	output logic [vga_w-1:0]   vga_g,
	output logic [vga_w-1:0]   vga_b,
	output logic               vga_hs,
	output logic               vga_vs
);

	// repeat the 2-bit level so 3 maps to full scale
	function automatic logic [vga_w-1:0] widen(input logic [color_w-1:0] c);
		return {c, c, c};
	endfunction

	logic [vga_w-1:0] wide_r;
	logic [vga_w-1:0] wide_g;
	logic [vga_w-1:0] wide_b;
	logic [vga_w-1:0] pal_r;
	logic [vga_w-1:0] pal_g;
	logic [vga_w-1:0] pal_b;

	assign wide_r = widen(core_r);
	assign wide_g = widen(core_g);
	assign wide_b = widen(core_b);

	always_comb begin
		if (mode >= mode_color) begin
			// colour monitor, codes 2 and 3
			pal_r = wide_r;
			pal_g = wide_g;
			pal_b = wide_b;
		end else if (mode == mode_green) begin
			// green phosphor look
			pal_r = '0;
			pal_g = wide_g;
			pal_b = '0;
		end else begin
			// gray, the original MZ80K screen is driven from green
			pal_r = wide_g;
			pal_g = wide_g;
			pal_b = wide_g;
		end
	end

	// colour and syncs share one register stage to stay aligned
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r <= pal_r;
			vga_g <= pal_g;
			vga_b <= pal_b;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
		end
	end

endmodule

// File: rtl/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac
	import mz80k_pkg::*;
(
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [dac_w-1:0] level,
	output logic             dac_out
);

	logic [dac_w-1:0] acc;
	logic [dac_w:0]   sum; // one extra bit for the carry

	// first order loop, the carry density equals level / 2**dac_w
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
			dac_out <= 1'b0;
		end else begin
			acc <= sum[dac_w-1:0]; // residue wraps around
			dac_out <= sum[dac_w]; // board RC filter smooths this
		end
	end

endmodule

// File: rtl/mz80k_shell.sv
`timescale 1ns/1ps

module mz80k_shell
	import mz80k_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 pll_locked,
	input  logic [1:0]           buttons,
	input  logic [31:0]          status,
	input  logic [ps2_key_w-1:0] ps2_key,
	input  logic [color_w-1:0]   core_r,
	input  logic [color_w-1:0]   core_g,
	input  logic [color_w-1:0]   core_b,
	input  logic                 core_hs,
	input  logic                 core_vs,
	input  logic                 core_audio,
	output logic                 core_reset,
	output logic                 key_strobe,
	output logic [7:0]           key_code,
	output logic                 key_extended,
	output logic                 key_pressed,
	output logic                 shift_held,
	output logic [vga_w-1:0]     vga_r,
	output logic [vga_w-1:0]     vga_g,
	output logic [vga_w-1:0]     vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 audio_l,
	output logic                 audio_r
);

	logic [1:0]       screen_mode;
	logic [dac_w-1:0] audio_level;

	// menu option O34 selects the monitor type
	assign screen_mode = status[status_mode_lo+1:status_mode_lo];

	// the tone is a single bit, full scale or silence
	assign audio_level = {dac_w{core_audio}};

	// mono core, same stream on both pins
	assign audio_r = audio_l;

	reset_sequencer u_reset_sequencer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pll_locked  (pll_locked),
		.hold_button (buttons[1]),
		.menu_reset  (status[status_menu_reset]),
		.trig_reset  (status[status_trig_reset]),
		.core_reset  (core_reset)
	);

	key_event_decoder u_key_event_decoder (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ps2_key      (ps2_key),
		.key_strobe   (key_strobe),
		.key_code     (key_code),
		.key_extended (key_extended),
		.key_pressed  (key_pressed),
		.shift_held   (shift_held)
	);

	video_palette u_video_palette (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.mode    (screen_mode),
		.core_r  (core_r),
		.core_g  (core_g),
		.core_b  (core_b),
		.core_hs (core_hs),
		.core_vs (core_vs),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.level   (audio_level),
		.dac_out (audio_l)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys; // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1 rst_n = 1'b1; // released off the edge like the other inputs
	end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic        clk_sys,
	input  logic        go,
	input  int          test_id,
	input  int          kind,
	input  logic [31:0] exp_word,
	input  logic [31:0] exp_value,
	input  logic [31:0] status,
	input  logic [1:0]  core_r,
	input  logic [1:0]  core_g,
	input  logic [1:0]  core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic        core_reset,
	input  logic        key_strobe,
	input  logic [7:0]  key_code,
	input  logic        key_extended,
	input  logic        key_pressed,
	input  logic        shift_held,
	input  logic [5:0]  vga_r,
	input  logic [5:0]  vga_g,
	input  logic [5:0]  vga_b,
	input  logic        vga_hs,
	input  logic        vga_vs,
	input  logic        audio_l,
	input  logic        audio_r,
	output logic        check_done,
	output int          pass_count,
	output int          fail_count
);

	localparam int kind_reset = 0;
	localparam int kind_key = 1;
	localparam int kind_video = 2;
	localparam int kind_audio = 3;

	int test_errors;

	initial begin
		check_done = 1'b0;
		pass_count = 0;
		fail_count = 0;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0d ns %s expected %0h actual %0h", $time, name, expected,
				actual);
			test_errors++;
		end
	endtask

	// each 2-bit level repeated three times
	function automatic logic [5:0] widen(input logic [1:0] c);
		return {c, c, c};
	endfunction

	// wait for the next edge, sample away from it
	task automatic next_sample();
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic check_reset();
		int edges;
		edges = 0;
		compare("core_reset", 32'd1, 32'(core_reset)); // went high on the edge after the source
		while (edges < 300) begin
			next_sample();
			edges++;
			if (!core_reset)
				break;
		end
		if (core_reset) begin
			$display("core_reset never fell after the sources cleared");
			test_errors++;
		end else begin
			compare("core_reset release edge", exp_value, 32'(edges));
		end
	endtask

	task automatic check_key();
		logic [31:0] word;
		word = exp_word;
		next_sample();
		if (exp_value[0]) begin
			if (!key_strobe) begin
				$display("key_strobe missing one cycle after the toggle flipped");
				test_errors++;
			end else begin
				compare("key_code", 32'(word[7:0]), 32'(key_code));
				compare("key_extended", 32'(word[8]), 32'(key_extended));
				compare("key_pressed", 32'(word[9]), 32'(key_pressed));
			end
		end else begin
			compare("key_strobe", 32'd0, 32'(key_strobe));
		end
		compare("shift_held", 32'(exp_value[1]), 32'(shift_held));
		next_sample();
		compare("key_strobe", 32'd0, 32'(key_strobe)); // strobe lasts one cycle only
	endtask

	task automatic check_video();
		logic [1:0] mode;
		logic [5:0] er;
		logic [5:0] eg;
		logic [5:0] eb;
		logic hs;
		logic vs;
		mode = status[4:3];
		hs = core_hs;
		vs = core_vs;
		eg = widen(core_g);
		if (mode == 2'd0) begin
			er = eg;
			eb = eg;
		end else if (mode == 2'd1) begin
			er = 6'd0;
			eb = 6'd0;
		end else begin
			er = widen(core_r);
			eb = widen(core_b);
		end
		next_sample();
		compare("vga_r", 32'(er), 32'(vga_r));
		compare("vga_g", 32'(eg), 32'(vga_g));
		compare("vga_b", 32'(eb), 32'(vga_b));
		compare("vga_hs", 32'(hs), 32'(vga_hs));
		compare("vga_vs", 32'(vs), 32'(vga_vs));
	endtask

	task automatic check_audio();
		logic bits_l [16];
		logic bits_r [16];
		int highs_l;
		int highs_r;
		next_sample(); // first output is not counted
		for (int i = 0; i < 16; i++) begin
			next_sample();
			bits_l[i] = audio_l;
			bits_r[i] = audio_r;
		end
		for (int s = 0; s <= 8; s++) begin
			highs_l = 0;
			highs_r = 0;
			for (int i = s; i < s + 8; i++) begin
				if (bits_l[i])
					highs_l++;
				if (bits_r[i])
					highs_r++;
			end
			compare("audio_l highs in 8", exp_value, 32'(highs_l));
			compare("audio_r highs in 8", exp_value, 32'(highs_r));
		end
	endtask

	always @(posedge go) begin
		check_done = 1'b0;
		test_errors = 0;
		case (kind)
			kind_reset: check_reset();
			kind_key:   check_key();
			kind_video: check_video();
			kind_audio: check_audio();
			default: begin
				$display("unknown test kind %0d", kind);
				test_errors++;
			end
		endcase
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0d kind %0d passed", test_id, kind);
		end else begin
			fail_count++;
			$display("test %0d kind %0d failed with %0d errors", test_id, kind, test_errors);
		end
		check_done = 1'b1;
	end

endmodule

// File: testbench/tb_mz80k_shell.sv
`timescale 1ns/1ps

module tb_mz80k_shell;

	localparam int kind_reset = 0;
	localparam int kind_key = 1;
	localparam int kind_video = 2;
	localparam int kind_audio = 3;
	localparam int max_entries = 32;

	logic clk_sys;
	logic rst_n;
	logic pll_locked;
	logic [1:0] buttons;
	logic [31:0] status;
	logic [10:0] ps2_key;
	logic [1:0] core_r;
	logic [1:0] core_g;
	logic [1:0] core_b;
	logic core_hs;
	logic core_vs;
	logic core_audio;
	logic core_reset;
	logic key_strobe;
	logic [7:0] key_code;
	logic key_extended;
	logic key_pressed;
	logic shift_held;
	logic [5:0] vga_r;
	logic [5:0] vga_g;
	logic [5:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic audio_l;
	logic audio_r;

	logic go;
	logic check_done;
	int test_id;
	int kind;
	logic [31:0] exp_word;
	logic [31:0] exp_value;
	int pass_count;
	int fail_count;

	int kind_tab [max_entries];
	logic [31:0] stim_tab [max_entries];
	logic [31:0] exp_tab [max_entries];
	int num_entries;
	int cycle_cnt;
	int cycle_limit;
	integer seed;
	logic toggle_state;

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	mz80k_shell u_dut (
		.clk_sys (clk_sys), .rst_n (rst_n), .pll_locked (pll_locked),
		.buttons (buttons), .status (status), .ps2_key (ps2_key),
		.core_r (core_r), .core_g (core_g), .core_b (core_b),
		.core_hs (core_hs), .core_vs (core_vs), .core_audio (core_audio),
		.core_reset (core_reset), .key_strobe (key_strobe), .key_code (key_code),
		.key_extended (key_extended), .key_pressed (key_pressed),
		.shift_held (shift_held), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.vga_hs (vga_hs), .vga_vs (vga_vs), .audio_l (audio_l), .audio_r (audio_r)
	);

	tb_checker u_checker (
		.clk_sys (clk_sys), .go (go), .test_id (test_id), .kind (kind),
		.exp_word (exp_word), .exp_value (exp_value), .status (status),
		.core_r (core_r), .core_g (core_g), .core_b (core_b),
		.core_hs (core_hs), .core_vs (core_vs), .core_reset (core_reset),
		.key_strobe (key_strobe), .key_code (key_code), .key_extended (key_extended),
		.key_pressed (key_pressed), .shift_held (shift_held),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.vga_hs (vga_hs), .vga_vs (vga_vs), .audio_l (audio_l), .audio_r (audio_r),
		.check_done (check_done), .pass_count (pass_count), .fail_count (fail_count)
	);

	task automatic add_entry(input int k, input logic [31:0] s, input logic [31:0] e);
		kind_tab[num_entries] = k;
		stim_tab[num_entries] = s;
		exp_tab[num_entries] = e;
		num_entries++;
	endtask

	// reset stim: 0 lock, 1 trigger bit, 2 button, 3 menu bit; expect fall edge count
	// key stim: bit 16 flips the toggle, low bits are the word; expect {shift, strobe}
	// video stim: {vs, hs, mode}; audio stim: tone bit, expect highs per 8 outputs
	task automatic fill_table();
		num_entries = 0;
		add_entry(kind_reset, 32'd0, 32'd257);
		add_entry(kind_reset, 32'd1, 32'd257);
		add_entry(kind_reset, 32'd2, 32'd257);
		add_entry(kind_reset, 32'd3, 32'd257);
		add_entry(kind_key, 32'h1021c, 32'h1);
		add_entry(kind_key, 32'h0021c, 32'h0);
		add_entry(kind_key, 32'h10212, 32'h3);
		add_entry(kind_key, 32'h10059, 32'h1);
		add_entry(kind_key, 32'h10312, 32'h1);
		add_entry(kind_key, 32'h10175, 32'h1);
		for (int m = 0; m < 8; m++)
			add_entry(kind_video, (32'(m) ^ 32'(m >> 1)) | (32'(m % 2) << 3), 32'd0);
		add_entry(kind_audio, 32'd1, 32'd7);
		add_entry(kind_audio, 32'd0, 32'd0);
		add_entry(kind_audio, 32'd1, 32'd7);
	endtask

	task automatic set_source(input logic [31:0] src, input logic active);
		case (src[1:0])
			2'd0: pll_locked = !active;
			2'd1: status[5] = active;
			2'd2: buttons[1] = active;
			default: status[0] = active;
		endcase
	endtask

	task automatic apply_entry(input int i);
		logic [31:0] s;
		logic [31:0] rnd;
		s = stim_tab[i];
		@(posedge clk_sys);
		#1;
		if (kind_tab[i] == kind_reset) begin
			set_source(s, 1'b1);
			@(posedge clk_sys);
			#1;
			set_source(s, 1'b0);
		end else if (kind_tab[i] == kind_key) begin
			if (s[16])
				toggle_state = ~toggle_state;
			ps2_key = {toggle_state, s[9:0]};
		end else if (kind_tab[i] == kind_video) begin
			status[4:3] = s[1:0];
			core_hs = s[2];
			core_vs = s[3];
			rnd = $random(seed);
			core_r = rnd[1:0];
			core_g = rnd[3:2];
			core_b = rnd[5:4];
		end else begin
			core_audio = s[0];
		end
		test_id = i;
		kind = kind_tab[i];
		exp_word = 32'(ps2_key);
		exp_value = exp_tab[i];
		go = 1'b1;
		if (kind_tab[i] == kind_video) begin
			@(posedge clk_sys);
			#1;
			// inputs after the sampling edge must not show up until the next one
			core_hs = ~core_hs;
			core_vs = ~core_vs;
			core_r = ~core_r;
			core_g = ~core_g;
			core_b = ~core_b;
		end
		@(posedge check_done);
		go = 1'b0;
	endtask

	initial begin
		seed = 31099;
		pll_locked = 1'b0;
		buttons = 2'b00;
		status = 32'd0;
		ps2_key = 11'd0;
		core_r = 2'd0;
		core_g = 2'd0;
		core_b = 2'd0;
		core_hs = 1'b0;
		core_vs = 1'b0;
		core_audio = 1'b0;
		go = 1'b0;
		test_id = 0;
		kind = 0;
		exp_word = 32'd0;
		exp_value = 32'd0;
		toggle_state = 1'b0;
		fill_table();
		cycle_limit = num_entries * 300 + 100;
		@(posedge rst_n);
		for (int i = 0; i < num_entries; i++)
			apply_entry(i);
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count == num_entries) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// stops a run where some check never completes
	initial cycle_cnt = 0;

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, test %0d did not finish", cycle_cnt, test_id);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: vlog.f
rtl/mz80k_pkg.sv
rtl/reset_sequencer.sv
rtl/key_event_decoder.sv
rtl/video_palette.sv
rtl/sigma_delta_dac.sv
rtl/mz80k_shell.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_mz80k_shell.sv

// File: run.sh
#!/bin/sh
# build and run the shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mz80k_shell \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
